//--- files.f
logic/csr_pkg.sv
logic/csr_trap_regs.sv
logic/csr_intr.sv
logic/csr_timer.sv
logic/csr_save_bank.sv
logic/csr_read_mux.sv
logic/csr_top.sv
sim/csr_chk.sv
sim/csr_tb.sv

//--- logic/csr_intr.sv
`timescale 1ns/1ps

module csr_intr (
    input  logic                                clk,
    input  logic                                rst,
    input  csr_pkg::csr_wr_t                    csr_wr_i,
    input  logic [csr_pkg::HWI_W-1:0]           hwi_i,
    input  logic                                timer_irq_i,
    input  logic                                crmd_ie_i,
    output logic [csr_pkg::XLEN-1:0]            ecfg_o,
    output logic [csr_pkg::ESTAT_IS_W-1:0]      estat_is_o,
    output logic                                interrupt_o
);
    import csr_pkg::*;

    logic [XLEN-1:0]       ecfg_q;
    logic [ESTAT_IS_W-1:0] is_q;     // sw and hwi bits only
    logic [ESTAT_IS_W-1:0] is_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_q <= '0;
            is_q   <= '0;
        end else begin
            if (csr_wr_i.en && csr_wr_i.addr == CSR_ECFG) begin
                ecfg_q <= csr_wr_i.data & ECFG_LIE_MASK;
            end
            if (csr_wr_i.en && csr_wr_i.addr == CSR_ESTAT) begin
                is_q <= (is_q & ~ESTAT_SW_MASK) | (csr_wr_i.data[ESTAT_IS_W-1:0] & ESTAT_SW_MASK);
            end
            is_q[ESTAT_HWI_LSB +: HWI_W] <= hwi_i; // sampled every cycle
        end
    end

    always_comb begin
        is_full               = is_q;
        is_full[ESTAT_TI_BIT] = timer_irq_i;
    end

    assign ecfg_o      = ecfg_q;
    assign estat_is_o  = is_full;
    assign interrupt_o = (|(ecfg_q[ESTAT_IS_W-1:0] & is_full)) & crmd_ie_i;

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    localparam int XLEN  = 32;
    localparam int HWI_W = 8;

    // architectural CSR numbers
    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef struct packed {
        logic             en;
        csr_addr_e        addr;
        logic [XLEN-1:0]  data;
    } csr_wr_t;

    typedef struct packed {
        logic             valid;
        logic [5:0]       ecode;
        logic [8:0]       esubcode;
        logic [XLEN-1:0]  pc;
    } trap_t;

    localparam logic [XLEN-1:0] CRMD_RESET = 32'h0000_0008; // DA=1
    localparam int              CRMD_PLV_LSB = 0;
    localparam int              CRMD_IE_BIT  = 2;
    localparam logic [XLEN-1:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [XLEN-1:0] PRMD_WMASK   = 32'h0000_0007;

    localparam logic [XLEN-1:0] ECFG_LIE_MASK = 32'h0000_1bff; // 9:0 and 12:11

    localparam int                    ESTAT_IS_W    = 13;
    localparam logic [ESTAT_IS_W-1:0] ESTAT_SW_MASK = 13'h0003;
    localparam int                    ESTAT_TI_BIT  = 11;
    localparam int                    ESTAT_HWI_LSB = 2;
    localparam int                    ECODE_LSB     = 16;
    localparam int                    ESUBCODE_LSB  = 22;

    localparam logic [XLEN-1:0] EENTRY_MASK = 32'hffff_ffc0;

    localparam int              TCFG_EN_BIT       = 0;
    localparam int              TCFG_PERIODIC_BIT = 1;
    localparam logic [XLEN-1:0] TVAL_INIT_MASK    = 32'hffff_fffc;
    localparam int              TICLR_CLR_BIT     = 0;

endpackage

//--- logic/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux (
    input  logic                                rd_en_i,
    input  csr_pkg::csr_addr_e                  rd_addr_i,
    input  logic [csr_pkg::XLEN-1:0]            crmd_i,
    input  logic [csr_pkg::XLEN-1:0]            prmd_i,
    input  logic [csr_pkg::XLEN-1:0]            era_i,
    input  logic [csr_pkg::XLEN-1:0]            eentry_i,
    input  logic [14:0]                         ecode_field_i,
    input  logic [csr_pkg::XLEN-1:0]            ecfg_i,
    input  logic [csr_pkg::ESTAT_IS_W-1:0]      estat_is_i,
    input  logic [csr_pkg::XLEN-1:0]            tcfg_i,
    input  logic [csr_pkg::XLEN-1:0]            tval_i,
    input  logic [3:0][csr_pkg::XLEN-1:0]       save_i,
    input  logic [csr_pkg::XLEN-1:0]            tid_i,
    output logic [csr_pkg::XLEN-1:0]            rd_data_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] estat;

    // estat is spread over two banks
    always_comb begin
        estat                        = '0;
        estat[ESTAT_IS_W-1:0]        = estat_is_i;
        estat[ECODE_LSB +: 6]        = ecode_field_i[5:0];
        estat[ESUBCODE_LSB +: 9]     = ecode_field_i[14:6];
    end

    always_comb begin
        rd_data_o = '0;
        if (rd_en_i) begin
            case (rd_addr_i)
                CSR_CRMD:   rd_data_o = crmd_i;
                CSR_PRMD:   rd_data_o = prmd_i;
                CSR_ECFG:   rd_data_o = ecfg_i;
                CSR_ESTAT:  rd_data_o = estat;
                CSR_ERA:    rd_data_o = era_i;
                CSR_EENTRY: rd_data_o = eentry_i;
                CSR_SAVE0:  rd_data_o = save_i[0];
                CSR_SAVE1:  rd_data_o = save_i[1];
                CSR_SAVE2:  rd_data_o = save_i[2];
                CSR_SAVE3:  rd_data_o = save_i[3];
                CSR_TID:    rd_data_o = tid_i;
                CSR_TCFG:   rd_data_o = tcfg_i;
                CSR_TVAL:   rd_data_o = tval_i;
                default:    rd_data_o = '0;  // ticlr is write-only
            endcase
        end
    end

endmodule

//--- logic/csr_save_bank.sv
`timescale 1ns/1ps

module csr_save_bank (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_pkg::csr_wr_t              csr_wr_i,
    output logic [3:0][csr_pkg::XLEN-1:0] save_o,
    output logic [csr_pkg::XLEN-1:0]      tid_o
);
    import csr_pkg::*;

    logic [3:0][XLEN-1:0] save_q;
    logic [XLEN-1:0]      tid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            save_q <= '0;
            tid_q  <= '0;
        end else if (csr_wr_i.en) begin
            case (csr_wr_i.addr)
                CSR_SAVE0: save_q[0] <= csr_wr_i.data;
                CSR_SAVE1: save_q[1] <= csr_wr_i.data;
                CSR_SAVE2: save_q[2] <= csr_wr_i.data;
                CSR_SAVE3: save_q[3] <= csr_wr_i.data;
                CSR_TID:   tid_q     <= csr_wr_i.data;
                default: ;
            endcase
        end
    end

    assign save_o = save_q;
    assign tid_o  = tid_q;

endmodule

//--- logic/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_wr_t         csr_wr_i,
    output logic [csr_pkg::XLEN-1:0] tcfg_o,
    output logic [csr_pkg::XLEN-1:0] tval_o,
    output logic                     timer_irq_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] tcfg_q;
    logic [XLEN-1:0] tval_q;
    logic            en_q;
    logic            pend_q;

    logic tcfg_we;
    logic ticlr_clr;
    logic expire;

    assign tcfg_we   = csr_wr_i.en && (csr_wr_i.addr == CSR_TCFG);
    assign ticlr_clr = csr_wr_i.en && (csr_wr_i.addr == CSR_TICLR)
                       && csr_wr_i.data[TICLR_CLR_BIT];
    assign expire    = en_q && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q <= '0;
            tval_q <= '0;
            en_q   <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_q <= csr_wr_i.data;
            tval_q <= csr_wr_i.data & TVAL_INIT_MASK;
            en_q   <= csr_wr_i.data[TCFG_EN_BIT];
        end else if (expire) begin
            // periodic reloads init, one-shot parks at all ones
            tval_q <= tcfg_q[TCFG_PERIODIC_BIT] ? (tcfg_q & TVAL_INIT_MASK) : '1;
            en_q   <= tcfg_q[TCFG_PERIODIC_BIT];
        end else if (en_q) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // sticky until TICLR
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= 1'b0;
        end else if (ticlr_clr) begin
            pend_q <= 1'b0;
        end else if (expire && !tcfg_we) begin
            pend_q <= 1'b1;
        end
    end

    assign tcfg_o      = tcfg_q;
    assign tval_o      = tval_q;
    assign timer_irq_o = pend_q;

endmodule

//--- logic/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_pkg::csr_wr_t              csr_wr_i,
    input  csr_pkg::trap_t                trap_i,
    input  logic                          ertn_i,
    input  logic [csr_pkg::HWI_W-1:0]     hwi_i,
    input  logic                          rd_en_i,
    input  csr_pkg::csr_addr_e            rd_addr_i,
    output logic [csr_pkg::XLEN-1:0]      rd_data_o,
    output logic [csr_pkg::XLEN-1:0]      crmd_o,
    output logic [csr_pkg::XLEN-1:0]      era_o,
    output logic [csr_pkg::XLEN-1:0]      eentry_o,
    output logic                          interrupt_o
);
    import csr_pkg::*;

    logic [XLEN-1:0]       prmd;
    logic [14:0]           ecode_field;
    logic                  crmd_ie;
    logic [XLEN-1:0]       ecfg;
    logic [ESTAT_IS_W-1:0] estat_is;
    logic                  timer_irq;
    logic [XLEN-1:0]       tcfg;
    logic [XLEN-1:0]       tval;
    logic [3:0][XLEN-1:0]  save;
    logic [XLEN-1:0]       tid;

    csr_trap_regs u_trap_regs (
        .clk           (clk),
        .rst           (rst),
        .csr_wr_i      (csr_wr_i),
        .trap_i        (trap_i),
        .ertn_i        (ertn_i),
        .crmd_o        (crmd_o),
        .prmd_o        (prmd),
        .era_o         (era_o),
        .eentry_o      (eentry_o),
        .ecode_field_o (ecode_field),
        .crmd_ie_o     (crmd_ie)
    );

    csr_intr u_intr (
        .clk         (clk),
        .rst         (rst),
        .csr_wr_i    (csr_wr_i),
        .hwi_i       (hwi_i),
        .timer_irq_i (timer_irq),
        .crmd_ie_i   (crmd_ie),
        .ecfg_o      (ecfg),
        .estat_is_o  (estat_is),
        .interrupt_o (interrupt_o)
    );

    csr_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .csr_wr_i    (csr_wr_i),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .timer_irq_o (timer_irq)
    );

    csr_save_bank u_save_bank (
        .clk      (clk),
        .rst      (rst),
        .csr_wr_i (csr_wr_i),
        .save_o   (save),
        .tid_o    (tid)
    );

    csr_read_mux u_read_mux (
        .rd_en_i       (rd_en_i),
        .rd_addr_i     (rd_addr_i),
        .crmd_i        (crmd_o),
        .prmd_i        (prmd),
        .era_i         (era_o),
        .eentry_i      (eentry_o),
        .ecode_field_i (ecode_field),
        .ecfg_i        (ecfg),
        .estat_is_i    (estat_is),
        .tcfg_i        (tcfg),
        .tval_i        (tval),
        .save_i        (save),
        .tid_i         (tid),
        .rd_data_o     (rd_data_o)
    );

endmodule

//--- logic/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_wr_t         csr_wr_i,
    input  csr_pkg::trap_t           trap_i,
    input  logic                     ertn_i,
    output logic [csr_pkg::XLEN-1:0] crmd_o,
    output logic [csr_pkg::XLEN-1:0] prmd_o,
    output logic [csr_pkg::XLEN-1:0] era_o,
    output logic [csr_pkg::XLEN-1:0] eentry_o,
    output logic [14:0]              ecode_field_o,
    output logic                     crmd_ie_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] crmd_q;
    logic [XLEN-1:0] prmd_q;
    logic [XLEN-1:0] era_q;
    logic [XLEN-1:0] eentry_q;
    logic [5:0]      ecode_q;
    logic [8:0]      esubcode_q;

    logic [XLEN-1:0] crmd_wr;
    logic [XLEN-1:0] prmd_wr;

    // only writable fields change
    assign crmd_wr = (crmd_q & ~CRMD_WMASK) | (csr_wr_i.data & CRMD_WMASK);
    assign prmd_wr = (prmd_q & ~PRMD_WMASK) | (csr_wr_i.data & PRMD_WMASK);

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q     <= CRMD_RESET;
            prmd_q     <= '0;
            era_q      <= '0;
            eentry_q   <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else if (trap_i.valid) begin
            // save mode, enter plv0 with interrupts off
            prmd_q[CRMD_PLV_LSB +: 2] <= crmd_q[CRMD_PLV_LSB +: 2];
            prmd_q[CRMD_IE_BIT]       <= crmd_q[CRMD_IE_BIT];
            crmd_q[CRMD_PLV_LSB +: 2] <= 2'b00;
            crmd_q[CRMD_IE_BIT]       <= 1'b0;
            era_q                     <= trap_i.pc;
            ecode_q                   <= trap_i.ecode;
            esubcode_q                <= trap_i.esubcode;
        end else if (ertn_i) begin
            crmd_q[CRMD_PLV_LSB +: 2] <= prmd_q[CRMD_PLV_LSB +: 2]; // pplv
            crmd_q[CRMD_IE_BIT]       <= prmd_q[CRMD_IE_BIT];       // pie
        end else if (csr_wr_i.en) begin
            case (csr_wr_i.addr)
                CSR_CRMD: begin
                    crmd_q <= crmd_wr;
                end
                CSR_PRMD: begin
                    prmd_q <= prmd_wr;
                end
                CSR_ERA: begin
                    era_q <= csr_wr_i.data;
                end
                CSR_EENTRY: begin
                    eentry_q <= csr_wr_i.data & EENTRY_MASK; // 64-byte aligned
                end
                default: ;
            endcase
        end
    end

    assign crmd_o        = crmd_q;
    assign prmd_o        = prmd_q;
    assign era_o         = era_q;
    assign eentry_o      = eentry_q;
    assign ecode_field_o = {esubcode_q, ecode_q};
    assign crmd_ie_o     = crmd_q[CRMD_IE_BIT];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module csr_tb -o csr_sim

result=$(./obj_dir/csr_sim 2>&1 || true)
echo "$result"

echo "$result" | grep -q "ALL TESTS PASSED"

//--- sim/csr_chk.sv
`timescale 1ns/1ps

module csr_chk (
    input logic                           clk,
    input logic                           rst,
    input csr_pkg::csr_wr_t               csr_wr_i,
    input csr_pkg::trap_t                 trap_i,
    input logic                           ertn_i,
    input logic [csr_pkg::XLEN-1:0]       crmd_i,
    input logic [csr_pkg::XLEN-1:0]       prmd_i,
    input logic [csr_pkg::ESTAT_IS_W-1:0] estat_is_i,
    input logic                           interrupt_i
);
    import csr_pkg::*;

    logic ticlr_clr;

    assign ticlr_clr = csr_wr_i.en && (csr_wr_i.addr == CSR_TICLR)
                       && csr_wr_i.data[TICLR_CLR_BIT];

    irq_low_after_reset: assert property (@(posedge clk) rst |=> !interrupt_i)
        else $error("interrupt_o high in the cycle after reset");

    // an exception on the same edge takes over
    ertn_restores_ie: assert property (@(posedge clk) disable iff (rst)
        (ertn_i && !trap_i.valid) |=> (crmd_i[CRMD_IE_BIT] == $past(prmd_i[CRMD_IE_BIT])))
        else $error("CRMD.IE not restored from PRMD on ertn");

    ticlr_clears_ti: assert property (@(posedge clk) disable iff (rst)
        ticlr_clr |=> !estat_is_i[ESTAT_TI_BIT])
        else $error("ESTAT timer bit still set after TICLR clear");

endmodule

bind csr_top csr_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .csr_wr_i    (csr_wr_i),
    .trap_i      (trap_i),
    .ertn_i      (ertn_i),
    .crmd_i      (crmd_o),
    .prmd_i      (prmd),
    .estat_is_i  (estat_is),
    .interrupt_i (interrupt_o)
);

//--- sim/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;
    import csr_pkg::*;

    localparam int CLK_NS       = 8;
    localparam int RST_CYCLES   = 3;
    localparam int RAND_CYCLES  = 1500;
    localparam int TRAP_ROUNDS  = 40;
    localparam int TIMER_ROUNDS = 12;
    localparam int TIMER_MAX_N  = 60;
    localparam int INTR_CYCLES  = 1500;
    localparam int TOTAL_CYCLES = RST_CYCLES + 20 + RAND_CYCLES + TRAP_ROUNDS * 8
                                + TIMER_ROUNDS * (4 * (TIMER_MAX_N + 8) + 20) + INTR_CYCLES;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_NS + 2000;

    logic             clk;
    logic             rst;
    csr_wr_t          csr_wr;
    trap_t            trap;
    logic             ertn;
    logic [HWI_W-1:0] hwi;
    logic             rd_en;
    csr_addr_e        rd_addr;
    logic [XLEN-1:0]  rd_data;
    logic [XLEN-1:0]  crmd;
    logic [XLEN-1:0]  era;
    logic [XLEN-1:0]  eentry;
    logic             irq;

    // applied at the coming rising edge
    logic             n_rst;
    csr_wr_t          n_wr;
    trap_t            n_trap;
    logic             n_ertn;
    logic [HWI_W-1:0] n_hwi;
    logic             n_rd_en;
    csr_addr_e        n_rd_addr;

    // reference model state
    logic [XLEN-1:0]  m_crmd;
    logic [XLEN-1:0]  m_prmd;
    logic [XLEN-1:0]  m_era;
    logic [XLEN-1:0]  m_eentry;
    logic [5:0]       m_ecode;
    logic [8:0]       m_esub;
    logic [XLEN-1:0]  m_ecfg;
    logic [1:0]       m_sw;
    logic [7:0]       m_hwi;
    logic [XLEN-1:0]  m_tcfg;
    logic [XLEN-1:0]  m_tval;
    logic             m_ten;
    logic             m_pend;
    logic [XLEN-1:0]  m_save [4];
    logic [XLEN-1:0]  m_tid;

    integer    seed = 92568;
    csr_addr_e kept [14] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
                             CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID,
                             CSR_TCFG, CSR_TVAL, CSR_TICLR};

    csr_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .csr_wr_i    (csr_wr),
        .trap_i      (trap),
        .ertn_i      (ertn),
        .hwi_i       (hwi),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .crmd_o      (crmd),
        .era_o       (era),
        .eentry_o    (eentry),
        .interrupt_o (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test sequence still running after %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // mostly kept addresses, now and then a hole in the map
    function automatic csr_addr_e pick_addr();
        logic [31:0] r;
        int          idx;
        r = rand_word();
        if (r[31:29] == 3'd0) begin
            return csr_addr_e'(r[13:0] | 14'h200);
        end
        idx = int'(r[15:0]) % 14;
        return kept[idx];
    endfunction

    function automatic logic [XLEN-1:0] model_estat();
        logic [XLEN-1:0] v;
        v        = '0;
        v[1:0]   = m_sw;
        v[9:2]   = m_hwi;
        v[11]    = m_pend;
        v[21:16] = m_ecode;
        v[30:22] = m_esub;
        return v;
    endfunction

    function automatic logic model_irq();
        logic [XLEN-1:0] estat;
        estat = model_estat();
        return (|(m_ecfg[12:0] & estat[12:0])) & m_crmd[2];
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic en, input csr_addr_e addr);
        logic [XLEN-1:0] v;
        v = '0;
        if (en) begin
            case (addr)
                CSR_CRMD:   v = m_crmd;
                CSR_PRMD:   v = m_prmd;
                CSR_ECFG:   v = m_ecfg;
                CSR_ESTAT:  v = model_estat();
                CSR_ERA:    v = m_era;
                CSR_EENTRY: v = m_eentry;
                CSR_SAVE0:  v = m_save[0];
                CSR_SAVE1:  v = m_save[1];
                CSR_SAVE2:  v = m_save[2];
                CSR_SAVE3:  v = m_save[3];
                CSR_TID:    v = m_tid;
                CSR_TCFG:   v = m_tcfg;
                CSR_TVAL:   v = m_tval;
                default:    v = '0;
            endcase
        end
        return v;
    endfunction

    // one rising edge of the model, from the inputs the DUT sees at that edge
    task automatic update_model();
        logic expire;
        logic tcfg_we;
        if (rst) begin
            m_crmd   = 32'h0000_0008;
            m_prmd   = '0;
            m_era    = '0;
            m_eentry = '0;
            m_ecode  = '0;
            m_esub   = '0;
            m_ecfg   = '0;
            m_sw     = '0;
            m_hwi    = '0;
            m_tcfg   = '0;
            m_tval   = '0;
            m_ten    = 1'b0;
            m_pend   = 1'b0;
            m_save   = '{default: '0};
            m_tid    = '0;
        end else begin
            if (trap.valid) begin
                m_prmd[2:0] = m_crmd[2:0];  // pplv, pie
                m_crmd[2:0] = 3'b000;
                m_era       = trap.pc;
                m_ecode     = trap.ecode;
                m_esub      = trap.esubcode;
            end else if (ertn) begin
                m_crmd[2:0] = m_prmd[2:0];
            end else if (csr_wr.en) begin
                case (csr_wr.addr)
                    CSR_CRMD:   m_crmd = (m_crmd & ~32'h1ff) | (csr_wr.data & 32'h1ff);
                    CSR_PRMD:   m_prmd = csr_wr.data & 32'h7;
                    CSR_ERA:    m_era = csr_wr.data;
                    CSR_EENTRY: m_eentry = {csr_wr.data[31:6], 6'b0};
                    default: ;
                endcase
            end
            if (csr_wr.en) begin
                case (csr_wr.addr)
                    CSR_ECFG:  m_ecfg = csr_wr.data & 32'h1bff;
                    CSR_ESTAT: m_sw = csr_wr.data[1:0];
                    CSR_SAVE0: m_save[0] = csr_wr.data;
                    CSR_SAVE1: m_save[1] = csr_wr.data;
                    CSR_SAVE2: m_save[2] = csr_wr.data;
                    CSR_SAVE3: m_save[3] = csr_wr.data;
                    CSR_TID:   m_tid = csr_wr.data;
                    default: ;
                endcase
            end
            m_hwi   = hwi;
            expire  = m_ten && (m_tval == 0);
            tcfg_we = csr_wr.en && (csr_wr.addr == CSR_TCFG);
            if (csr_wr.en && csr_wr.addr == CSR_TICLR && csr_wr.data[0]) begin
                m_pend = 1'b0;
            end else if (expire && !tcfg_we) begin
                m_pend = 1'b1;
            end
            if (tcfg_we) begin
                m_tcfg = csr_wr.data;
                m_tval = {csr_wr.data[31:2], 2'b00};
                m_ten  = csr_wr.data[0];
            end else if (expire) begin
                m_tval = m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : 32'hffff_ffff;
                m_ten  = m_tcfg[1];
            end else if (m_ten) begin
                m_tval = m_tval - 32'd1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("FAILED time=%0t signal=%s got=0x%h expected=0x%h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        check_value("rd_data_o", rd_data, model_read(rd_en, rd_addr));
        check_value("crmd_o", crmd, m_crmd);
        check_value("era_o", era, m_era);
        check_value("eentry_o", eentry, m_eentry);
        check_value("interrupt_o", {31'b0, irq}, {31'b0, model_irq()});
    endtask

    task automatic step();
        @(posedge clk);
        update_model();
        rst          <= n_rst;
        csr_wr       <= n_wr;
        trap         <= n_trap;
        ertn         <= n_ertn;
        hwi          <= n_hwi;
        rd_en        <= n_rd_en;
        rd_addr      <= n_rd_addr;
        n_wr.en      = 1'b0;  // pulses last one cycle
        n_trap.valid = 1'b0;
        n_ertn       = 1'b0;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic set_write(input csr_addr_e addr, input logic [XLEN-1:0] data);
        n_wr.en   = 1'b1;
        n_wr.addr = addr;
        n_wr.data = data;
    endtask

    // rd_addr must already point at ESTAT
    task automatic wait_timer_pending(input int limit, output int edges);
        edges = 0;
        while (rd_data[11] !== 1'b1) begin
            if (edges >= limit) begin
                $display("timer pending bit did not rise within %0d cycles", limit);
                $display("SOME TESTS FAILED");
                $fatal(1, "timer never expired");
            end
            step();
            edges++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] n_val;
        int          edges;

        rst       = 1'b1;
        csr_wr    = '0;
        trap      = '0;
        ertn      = 1'b0;
        hwi       = '0;
        rd_en     = 1'b0;
        rd_addr   = CSR_CRMD;
        n_rst     = 1'b1;
        n_wr      = '0;
        n_trap    = '0;
        n_ertn    = 1'b0;
        n_hwi     = '0;
        n_rd_en   = 1'b0;
        n_rd_addr = CSR_CRMD;

        repeat (RST_CYCLES - 1) step();
        n_rst = 1'b0;
        step();

        // reset values
        n_rd_en = 1'b1;
        for (int i = 0; i < 14; i++) begin
            n_rd_addr = kept[i];
            step();
            check_value("reset readback", rd_data, (kept[i] == CSR_CRMD) ? 32'h8 : 32'h0);
        end

        // random writes and reads
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = rand_word();
            if (r[0]) begin
                set_write(pick_addr(), rand_word());
            end
            n_rd_en   = (r[2:1] != 2'b00);
            n_rd_addr = pick_addr();
            n_hwi     = r[15:8];
            step();
        end

        // exception entry and return
        n_rd_en = 1'b1;
        for (int i = 0; i < TRAP_ROUNDS; i++) begin
            set_write(CSR_CRMD, rand_word());
            step();
            set_write(CSR_PRMD, rand_word());
            step();
            r               = rand_word();
            pc              = rand_word();
            n_trap.valid    = 1'b1;
            n_trap.ecode    = r[5:0];
            n_trap.esubcode = r[14:6];
            n_trap.pc       = pc;
            if (r[15]) begin
                set_write(CSR_CRMD, 32'h0000_0007); // same edge as the exception
            end
            n_rd_addr = CSR_ESTAT;
            step();
            step();
            check_value("era_o", era, pc);
            check_value("crmd_o plv ie", {29'b0, crmd[2:0]}, 32'h0);
            check_value("estat ecode", {26'b0, rd_data[21:16]}, {26'b0, r[5:0]});
            check_value("estat esubcode", {23'b0, rd_data[30:22]}, {23'b0, r[14:6]});
            n_rd_addr = CSR_PRMD;
            step();
            n_ertn    = 1'b1;
            n_rd_addr = CSR_CRMD;
            step();
            step();
        end

        // timer
        for (int i = 0; i < TIMER_ROUNDS; i++) begin
            n_rd_addr = CSR_ESTAT;
            set_write(CSR_TCFG, 32'h0);
            step();
            set_write(CSR_TICLR, 32'h1);
            step();
            step();
            r     = rand_word();
            n_val = {26'b0, r[7:4], 2'b00};
            set_write(CSR_TCFG, n_val | 32'h1);
            step();
            step();
            wait_timer_pending(TIMER_MAX_N + 8, edges);
            check_value("one-shot expiry edges", edges, n_val + 32'd1);
            n_rd_addr = CSR_TVAL;
            step();
            check_value("tval after one-shot", rd_data, 32'hffff_ffff);
            n_rd_addr = CSR_ESTAT;
            set_write(CSR_TICLR, 32'h1);
            step();
            step();
            check_value("estat timer bit", {31'b0, rd_data[11]}, 32'h0);

            n_val = {26'b0, (r[3:0] % 4'd15) + 4'd1, 2'b00};
            set_write(CSR_TCFG, n_val | 32'h3);
            step();
            step();
            wait_timer_pending(TIMER_MAX_N + 8, edges);
            check_value("periodic first expiry", edges, n_val + 32'd1);
            repeat (2) begin
                set_write(CSR_TICLR, 32'h1);
                step();
                step();
                wait_timer_pending(TIMER_MAX_N + 8, edges);
                check_value("periodic interval", edges + 2, n_val + 32'd1);
            end
        end

        // interrupt request under mixed traffic
        for (int i = 0; i < INTR_CYCLES; i++) begin
            r = rand_word();
            case (r[2:0])
                3'd0: set_write(CSR_ECFG, rand_word());
                3'd1: set_write(CSR_ESTAT, rand_word());
                3'd2: set_write(CSR_CRMD, rand_word());
                3'd3: set_write(CSR_TCFG, {24'b0, r[13:8], 2'b11});
                3'd4: set_write(CSR_TICLR, 32'h1);
                default: ;
            endcase
            if (r[3]) begin
                n_hwi = r[23:16];
            end
            n_rd_addr = pick_addr();
            step();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
